//--- source/lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [127:0] lc3b_line;
typedef logic [11:0] lc3b_wb_adr;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

typedef enum logic [3:0] {
	op_br = 4'b0000,
	op_add, op_ldb, op_stb, op_jsr, op_and, op_ldr, op_str,
	op_rti, op_not, op_ldi, op_sti, op_jmp, op_shf, op_lea, op_trap
} lc3b_opcode;

typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} lc3b_aluop;

// Writeback source
localparam logic [1:0] rfmux_alu = 2'd0;
localparam logic [1:0] rfmux_mem = 2'd1;
localparam logic [1:0] rfmux_adder = 2'd2;

// BR with nzp of 000, never taken
localparam lc3b_word nop_instruction = 16'h0000;

typedef struct packed {
	lc3b_aluop aluop;
	logic alumux_sel;
	logic load_regfile;
	logic load_cc;
	logic mem_read;
	logic mem_write;
	logic [1:0] regfilemux_sel;
	logic is_br;
	logic is_j;
} lc3b_control_word;

typedef struct packed {
	logic valid;
	lc3b_word pc;
	lc3b_word instruction;
} if_id_t;

typedef struct packed {
	logic valid;
	lc3b_control_word ctrl;
	lc3b_word sr1;
	lc3b_word sr2_imm;
	lc3b_word offset6;
	lc3b_word branch_offset;
	lc3b_nzp nzp;
	lc3b_reg dest;
	lc3b_word pc;
	lc3b_word store_data;
} id_ex_t;

typedef struct packed {
	logic valid;
	lc3b_control_word ctrl;
	lc3b_word alu_out;
	lc3b_word adder_out;
	lc3b_reg dest;
	lc3b_nzp nzp;
	lc3b_word store_data;
} ex_mem_t;

typedef struct packed {
	lc3b_word value;
	lc3b_reg dest;
	logic load_regfile;
} mem_wb_t;

localparam if_id_t if_id_bubble = '{valid: 1'b0, pc: 16'h0000, instruction: nop_instruction};

endpackage : lc3b_types

//--- source/alu.sv
`timescale 1ns/1ns

module alu
	import lc3b_types::*;
(
	input lc3b_aluop aluop,
	input lc3b_word a,
	input lc3b_word b,
	output lc3b_word f
);

always_comb begin
	case (aluop)
		alu_add: f = a + b;
		alu_and: f = a & b;
		alu_not: f = ~a;
		alu_pass: f = b;
		default: f = b;
	endcase
end

endmodule : alu

//--- source/regfile.sv
`timescale 1ns/1ns

module regfile
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_word in,
	input lc3b_reg dest,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);

lc3b_word data [8];

always_ff @(posedge clk) begin
	if (reset) begin
		for (int i = 0; i < 8; i++) begin
			data[i] <= '0;
		end
	end else if (load) begin
		data[dest] <= in;
	end
end

assign reg_a = data[src_a];
assign reg_b = data[src_b];

endmodule : regfile

//--- source/control_rom.sv
`timescale 1ns/1ns

module control_rom
	import lc3b_types::*;
(
	input lc3b_opcode opcode,
	output lc3b_control_word ctrl
);

always_comb begin
	ctrl = '0;
	case (opcode)
		op_add, op_and, op_not: begin
			ctrl.aluop = (opcode == op_add) ? alu_add :
				(opcode == op_and) ? alu_and : alu_not;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.regfilemux_sel = rfmux_alu;
		end
		op_ldr: begin
			// Base plus offset6 through the ALU
			ctrl.aluop = alu_add;
			ctrl.alumux_sel = 1'b1;
			ctrl.mem_read = 1'b1;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.regfilemux_sel = rfmux_mem;
		end
		op_str: begin
			ctrl.aluop = alu_add;
			ctrl.alumux_sel = 1'b1;
			ctrl.mem_write = 1'b1;
		end
		op_lea: begin
			ctrl.load_regfile = 1'b1;
			ctrl.regfilemux_sel = rfmux_adder;
		end
		op_br: ctrl.is_br = 1'b1;
		op_jmp: begin
			// Offset field is zero, so the ALU yields BaseR
			ctrl.aluop = alu_add;
			ctrl.alumux_sel = 1'b1;
			ctrl.is_j = 1'b1;
		end
		default: ;
	endcase
end

endmodule : control_rom

//--- source/stall_unit.sv
`timescale 1ns/1ns

module stall_unit
(
	input logic clk,
	input logic reset,
	input logic ifetch_resp,
	input logic mem_read,
	input logic mem_write,
	input logic mem_resp,
	output logic stall_pipeline
);

// wait_mem means the fetch is done, wait_ifetch means the data access is done
typedef enum logic [1:0] {st_idle, st_wait_mem, st_wait_ifetch} stall_state_t;

stall_state_t state;
stall_state_t state_next;
logic mem_req;

assign mem_req = mem_read | mem_write;

always_comb begin
	state_next = state;
	case (state)
		st_idle: begin
			stall_pipeline = !ifetch_resp || (mem_req && !mem_resp);
			if (ifetch_resp && mem_req && !mem_resp)
				state_next = st_wait_mem;
			else if (!ifetch_resp && mem_req && mem_resp)
				state_next = st_wait_ifetch;
		end
		st_wait_mem: begin
			stall_pipeline = !mem_resp;
			if (mem_resp)
				state_next = st_idle;
		end
		st_wait_ifetch: begin
			stall_pipeline = !ifetch_resp;
			if (ifetch_resp)
				state_next = st_idle;
		end
		default: begin
			stall_pipeline = 1'b1;
			state_next = st_idle;
		end
	endcase
end

always_ff @(posedge clk) begin
	if (reset)
		state <= st_idle;
	else
		state <= state_next;
end

// Memory answers only an outstanding data request
assert property (@(posedge clk) disable iff (reset) mem_resp |-> mem_req);

// Data request holds while its response is still owed
assert property (@(posedge clk) disable iff (reset) (state == st_wait_mem) |-> mem_req);

endmodule : stall_unit

//--- source/datapath.sv
`timescale 1ns/1ns

module datapath
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input lc3b_line ifetch_rdata,
	input lc3b_line mem_rdata,
	input lc3b_control_word ctrl,
	input logic stall_pipeline,
	output logic ifetch_read,
	output lc3b_wb_adr ifetch_address,
	output logic mem_read,
	output logic mem_write,
	output lc3b_wb_adr mem_address,
	output lc3b_line mem_wdata,
	output lc3b_word mem_sel,
	output lc3b_opcode opcode
);

function automatic lc3b_word line_word(lc3b_line line, logic [2:0] idx);
	return line[16 * idx +: 16];
endfunction

lc3b_word pc;
lc3b_word pc_plus2;
lc3b_word target;
logic taken;
if_id_t if_id, if_id_next;
id_ex_t id_ex, id_ex_next;
ex_mem_t ex_mem, ex_mem_next;
mem_wb_t mem_wb, mem_wb_next;
lc3b_nzp cc;
lc3b_nzp cc_next;
lc3b_word reg_a;
lc3b_word reg_b;
lc3b_word sext5;
lc3b_word alu_b;
lc3b_word alu_out;
lc3b_word mem_word;
lc3b_word wb_value;
lc3b_reg src_b;

// Fetch
assign ifetch_read = 1'b1;
assign ifetch_address = pc[15:4];
assign pc_plus2 = pc + 16'd2;
assign if_id_next = '{valid: 1'b1, pc: pc_plus2, instruction: line_word(ifetch_rdata, pc[3:1])};

// Decode
assign opcode = lc3b_opcode'(if_id.instruction[15:12]);
// Stores read their source register through port b
assign src_b = ctrl.mem_write ? if_id.instruction[11:9] : if_id.instruction[2:0];
assign sext5 = {{11{if_id.instruction[4]}}, if_id.instruction[4:0]};

regfile regfile (
	.clk,
	.reset,
	.load(mem_wb.load_regfile),
	.in(mem_wb.value),
	.dest(mem_wb.dest),
	.src_a(if_id.instruction[8:6]),
	.src_b(src_b),
	.reg_a(reg_a),
	.reg_b(reg_b)
);

always_comb begin
	id_ex_next.valid = if_id.valid;
	id_ex_next.ctrl = ctrl;
	id_ex_next.sr1 = reg_a;
	id_ex_next.sr2_imm = if_id.instruction[5] ? sext5 : reg_b;
	id_ex_next.offset6 = {{9{if_id.instruction[5]}}, if_id.instruction[5:0], 1'b0};
	id_ex_next.branch_offset = {{6{if_id.instruction[8]}}, if_id.instruction[8:0], 1'b0};
	id_ex_next.nzp = if_id.instruction[11:9];
	id_ex_next.dest = if_id.instruction[11:9];
	id_ex_next.pc = if_id.pc;
	id_ex_next.store_data = reg_b;
end

// Execute
assign alu_b = id_ex.ctrl.alumux_sel ? id_ex.offset6 : id_ex.sr2_imm;

alu alu (
	.aluop(id_ex.ctrl.aluop),
	.a(id_ex.sr1),
	.b(alu_b),
	.f(alu_out)
);

assign ex_mem_next = '{
	valid: id_ex.valid,
	ctrl: id_ex.ctrl,
	alu_out: alu_out,
	adder_out: id_ex.pc + id_ex.branch_offset,
	dest: id_ex.dest,
	nzp: id_ex.nzp,
	store_data: id_ex.store_data
};

// Memory
assign mem_read = ex_mem.valid & ex_mem.ctrl.mem_read;
assign mem_write = ex_mem.valid & ex_mem.ctrl.mem_write;
assign mem_address = ex_mem.alu_out[15:4];
assign mem_wdata = {8{ex_mem.store_data}};
assign mem_sel = 16'h0003 << {ex_mem.alu_out[3:1], 1'b0};
assign mem_word = line_word(mem_rdata, ex_mem.alu_out[3:1]);

always_comb begin
	case (ex_mem.ctrl.regfilemux_sel)
		rfmux_mem: wb_value = mem_word;
		rfmux_adder: wb_value = ex_mem.adder_out;
		default: wb_value = ex_mem.alu_out;
	endcase
end

assign cc_next = {wb_value[15], wb_value == 16'h0000, !wb_value[15] && wb_value != 16'h0000};
assign taken = ex_mem.valid & ((ex_mem.ctrl.is_br & |(ex_mem.nzp & cc)) | ex_mem.ctrl.is_j);
assign target = ex_mem.ctrl.is_j ? ex_mem.alu_out : ex_mem.adder_out;
assign mem_wb_next = '{
	value: wb_value,
	dest: ex_mem.dest,
	load_regfile: ex_mem.valid & ex_mem.ctrl.load_regfile
};

always_ff @(posedge clk) begin
	if (reset) begin
		pc <= '0;
		cc <= '0;
		if_id <= if_id_bubble;
		id_ex <= '0;
		ex_mem <= '0;
		mem_wb <= '0;
	end else if (!stall_pipeline) begin
		pc <= taken ? target : pc_plus2;
		// Redirect squashes everything younger than the branch
		if_id <= taken ? if_id_bubble : if_id_next;
		id_ex <= taken ? '0 : id_ex_next;
		ex_mem <= taken ? '0 : ex_mem_next;
		mem_wb <= mem_wb_next;
		if (ex_mem.valid && ex_mem.ctrl.load_cc)
			cc <= cc_next;
	end
end

assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write));

endmodule : datapath

//--- source/cpu.sv
`timescale 1ns/1ns

module cpu
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input lc3b_line ifetch_rdata,
	input logic ifetch_resp,
	input lc3b_line mem_rdata,
	input logic mem_resp,
	output logic ifetch_read,
	output lc3b_wb_adr ifetch_address,
	output logic mem_read,
	output logic mem_write,
	output lc3b_wb_adr mem_address,
	output lc3b_line mem_wdata,
	output lc3b_word mem_sel
);

lc3b_opcode opcode;
lc3b_control_word ctrl;
logic stall_pipeline;

datapath datapath (
	.clk,
	.reset,
	.ifetch_rdata,
	.mem_rdata,
	.ctrl,
	.stall_pipeline,
	.ifetch_read,
	.ifetch_address,
	.mem_read,
	.mem_write,
	.mem_address,
	.mem_wdata,
	.mem_sel,
	.opcode
);

control_rom control_rom (
	.opcode,
	.ctrl
);

stall_unit stall_unit (
	.clk,
	.reset,
	.ifetch_resp,
	.mem_read,
	.mem_write,
	.mem_resp,
	.stall_pipeline
);

endmodule : cpu

//--- dv/tb_line_memory.sv
`timescale 1ns/1ns

module tb_line_memory
	import lc3b_types::*;
(
	input logic clk,
	input logic read,
	input logic write,
	input lc3b_wb_adr address,
	input lc3b_line wdata,
	input lc3b_word sel,
	// Zero draws a random latency of 1 to 4 cycles
	input logic [2:0] fixed_latency,
	// Data side answers a request once and waits for it to change or drop
	input logic hold_after_resp,
	output lc3b_line rdata,
	output logic resp
);

lc3b_line mem [4096];
logic busy = 1'b0;
logic done = 1'b0;
logic cur_write = 1'b0;
lc3b_wb_adr cur_addr = '0;
logic [2:0] cnt = '0;
integer seed = 56;
logic req;

assign req = read | write;
assign rdata = mem[address];
assign resp = req && busy && !done && address == cur_addr && write == cur_write && cnt == 0;

always @(posedge clk) begin
	logic [2:0] lat;
	lat = (fixed_latency != 0) ? fixed_latency : 3'(($unsigned($random(seed)) % 4) + 1);
	if (!req) begin
		busy <= 1'b0;
		done <= 1'b0;
	end else if (!busy || address != cur_addr || write != cur_write) begin
		busy <= 1'b1;
		done <= 1'b0;
		cur_addr <= address;
		cur_write <= write;
		cnt <= lat - 3'd1;
	end else if (resp) begin
		if (write) begin
			for (int i = 0; i < 16; i++) begin
				if (sel[i])
					mem[address][8 * i +: 8] <= wdata[8 * i +: 8];
			end
		end
		if (hold_after_resp)
			done <= 1'b1;
		else
			cnt <= lat - 3'd1;
	end else if (cnt != 0) begin
		cnt <= cnt - 3'd1;
	end
end

endmodule : tb_line_memory

//--- dv/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu import lc3b_types::*; ();

logic clk;
logic reset;
lc3b_line ifetch_rdata;
lc3b_line mem_rdata;
lc3b_line mem_wdata;
logic ifetch_resp;
logic mem_resp;
logic ifetch_read;
logic mem_read;
logic mem_write;
lc3b_wb_adr ifetch_address;
lc3b_wb_adr mem_address;
lc3b_word mem_sel;
logic [2:0] fixed_lat;
integer seed = 56;
int sentinel_count = 0;
int errors;
int passes = 0;
int fails = 0;
lc3b_word prog[$];
lc3b_word arith_a;
lc3b_word arith_b;
logic [4:0] arith_imm;

cpu DUT (.*);

tb_line_memory imem (
	.clk, .read(ifetch_read), .write(1'b0), .address(ifetch_address), .wdata('0),
	.sel('0), .fixed_latency(fixed_lat), .hold_after_resp(1'b0),
	.rdata(ifetch_rdata), .resp(ifetch_resp)
);

tb_line_memory dmem (
	.clk, .read(mem_read), .write(mem_write), .address(mem_address), .wdata(mem_wdata),
	.sel(mem_sel), .fixed_latency(fixed_lat), .hold_after_resp(1'b1),
	.rdata(mem_rdata), .resp(mem_resp)
);

initial begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

// Sentinel lives at byte address 0x0FF0, word 0 of line 0x0FF
always @(negedge clk) begin
	if (mem_write && mem_resp && mem_address == 12'h0FF && mem_sel == 16'h0003)
		sentinel_count++;
end

function automatic lc3b_word encode(logic [3:0] op, logic [2:0] a, logic [2:0] b, logic [5:0] low);
	return {op, a, b, low};
endfunction

function automatic lc3b_word encode9(logic [3:0] op, logic [2:0] a, logic [8:0] off9);
	return {op, a, off9};
endfunction

task automatic emit(lc3b_word w);
	prog.push_back(w);
endtask

// Three nops keep every register write ahead of its readers
task automatic emit_spaced(lc3b_word w);
	emit(w);
	repeat (3) emit(nop_instruction);
endtask

task automatic put_data(int w, lc3b_word v);
	dmem.mem[w / 8][16 * (w % 8) +: 16] = v;
endtask

function automatic lc3b_word read_word(int w);
	return dmem.mem[w / 8][16 * (w % 8) +: 16];
endfunction

task automatic check_word(int w, lc3b_word expected);
	lc3b_word got;
	got = read_word(w);
	if (got !== expected) begin
		$display("error addr 0x%h got 0x%h expected 0x%h", 16'(w * 2), got, expected);
		errors++;
	end
endtask

task automatic check_signal(string name, logic [15:0] got, logic [15:0] expected);
	if (got !== expected) begin
		$display("error %s got 0x%h expected 0x%h", name, got, expected);
		errors++;
	end
endtask

// R7 points at the sentinel, R6 at the result area, R5 holds a marker
task automatic begin_program();
	prog.delete();
	errors = 0;
	emit_spaced(encode(4'b0110, 3'd7, 3'd0, 6'd0));
	emit_spaced(encode(4'b0110, 3'd6, 3'd0, 6'd1));
	emit_spaced(encode(4'b0110, 3'd5, 3'd0, 6'd2));
endtask

task automatic end_program();
	emit_spaced(encode(4'b0111, 3'd5, 3'd7, 6'd0));
	emit(encode9(4'b0000, 3'b111, 9'h1FF));
endtask

task automatic start_run();
	@(posedge clk);
	#2 reset = 1'b1;
	for (int i = 0; i < 4096; i++) begin
		imem.mem[i] = '0;
		dmem.mem[i] = '0;
	end
	for (int i = 0; i < prog.size(); i++)
		imem.mem[i / 8][16 * (i % 8) +: 16] = prog[i];
	put_data(0, 16'h0FF0);
	put_data(1, 16'h0200);
	put_data(2, 16'hA5A5);
endtask

task automatic check_idle();
	check_signal("mem_read", 16'(mem_read), 16'h0);
	check_signal("mem_write", 16'(mem_write), 16'h0);
	check_signal("ifetch_address", 16'(ifetch_address), 16'h0);
endtask

task automatic release_and_wait();
	int start;
	int i;
	repeat (15) begin
		@(posedge clk);
		@(negedge clk);
		check_idle();
	end
	@(posedge clk);
	#2 reset = 1'b0;
	@(negedge clk);
	check_idle();
	check_signal("ifetch_read", 16'(ifetch_read), 16'h1);
	start = sentinel_count;
	for (i = 0; i < 2000 && sentinel_count == start; i++)
		@(posedge clk);
	if (sentinel_count == start) begin
		$display("timeout waiting for sentinel store");
		errors++;
	end else begin
		repeat (40) @(posedge clk);
		if (sentinel_count - start != 1) begin
			$display("sentinel store seen %0d times instead of once", sentinel_count - start);
			errors++;
		end
	end
endtask

task automatic end_test(string name);
	if (errors == 0) begin
		passes++;
		$display("test %s ok", name);
	end else begin
		fails++;
		$display("test %s failed with %0d errors", name, errors);
	end
endtask

task automatic test_reset();
	begin_program();
	end_program();
	start_run();
	release_and_wait();
	end_test("reset");
endtask

task automatic test_arith(string name, bit redraw);
	lc3b_word imm;
	if (redraw) begin
		arith_a = 16'($random(seed));
		arith_b = 16'($random(seed));
		arith_imm = 5'($random(seed));
	end
	imm = {{11{arith_imm[4]}}, arith_imm};
	begin_program();
	emit_spaced(encode(4'b0110, 3'd1, 3'd0, 6'd3));
	emit_spaced(encode(4'b0110, 3'd2, 3'd0, 6'd4));
	emit_spaced(encode(4'b0001, 3'd3, 3'd1, 6'd2));
	emit_spaced(encode(4'b0111, 3'd3, 3'd6, 6'd0));
	emit_spaced(encode(4'b0001, 3'd3, 3'd1, {1'b1, arith_imm}));
	emit_spaced(encode(4'b0111, 3'd3, 3'd6, 6'd1));
	emit_spaced(encode(4'b0101, 3'd3, 3'd1, 6'd2));
	emit_spaced(encode(4'b0111, 3'd3, 3'd6, 6'd2));
	emit_spaced(encode(4'b0101, 3'd3, 3'd1, {1'b1, arith_imm}));
	emit_spaced(encode(4'b0111, 3'd3, 3'd6, 6'd3));
	emit_spaced(encode(4'b1001, 3'd3, 3'd1, 6'h3F));
	emit_spaced(encode(4'b0111, 3'd3, 3'd6, 6'd4));
	end_program();
	start_run();
	put_data(3, arith_a);
	put_data(4, arith_b);
	release_and_wait();
	check_word(256, arith_a + arith_b);
	check_word(257, arith_a + imm);
	check_word(258, arith_a & arith_b);
	check_word(259, arith_a & imm);
	check_word(260, ~arith_a);
	end_test(name);
endtask

task automatic test_memory();
	lc3b_word expected [16:31];
	begin_program();
	emit_spaced(encode(4'b0110, 3'd1, 3'd0, 6'd17));
	emit_spaced(encode(4'b0110, 3'd2, 3'd0, 6'd22));
	emit_spaced(encode(4'b0110, 3'd3, 3'd0, 6'd29));
	emit_spaced(encode(4'b0111, 3'd1, 3'd0, 6'd19));
	emit_spaced(encode(4'b0111, 3'd2, 3'd0, 6'd20));
	emit_spaced(encode(4'b0111, 3'd3, 3'd0, 6'd26));
	emit_spaced(encode(4'b0111, 3'd1, 3'd0, 6'd31));
	end_program();
	start_run();
	for (int w = 16; w < 32; w++) begin
		expected[w] = 16'(w * 16'h1357) ^ 16'hA0A0;
		put_data(w, expected[w]);
	end
	expected[19] = expected[17];
	expected[20] = expected[22];
	expected[26] = expected[29];
	expected[31] = expected[17];
	release_and_wait();
	for (int w = 16; w < 32; w++)
		check_word(w, expected[w]);
	end_test("memory");
endtask

task automatic test_branch();
	lc3b_word values [3];
	logic [2:0] cc;
	int jmp_target;
	values = '{16'h8001, 16'h0000, 16'h0123};
	begin_program();
	for (int v = 0; v < 3; v++) begin
		emit_spaced(encode(4'b0110, 3'd1, 3'd0, 6'(3 + v)));
		// Slot store runs only when the branch falls through
		for (int nzp = 0; nzp < 8; nzp++) begin
			emit(encode9(4'b0000, 3'(nzp), 9'd3));
			emit(encode(4'b0111, 3'd5, 3'd6, 6'(v * 8 + nzp)));
			emit(nop_instruction);
			emit(nop_instruction);
		end
	end
	emit_spaced(encode(4'b0110, 3'd4, 3'd0, 6'd6));
	jmp_target = prog.size() + 5;
	emit(encode(4'b1100, 3'd0, 3'd4, 6'd0));
	emit(encode(4'b0111, 3'd5, 3'd6, 6'd24));
	repeat (3) emit(nop_instruction);
	emit_spaced(encode(4'b0111, 3'd5, 3'd6, 6'd25));
	end_program();
	start_run();
	for (int v = 0; v < 3; v++)
		put_data(3 + v, values[v]);
	put_data(6, 16'(jmp_target * 2));
	release_and_wait();
	for (int v = 0; v < 3; v++) begin
		cc = values[v][15] ? 3'b100 : (values[v] == 0) ? 3'b010 : 3'b001;
		for (int nzp = 0; nzp < 8; nzp++)
			check_word(256 + v * 8 + nzp, ((3'(nzp) & cc) != 0) ? 16'h0000 : 16'hA5A5);
	end
	check_word(280, 16'h0000);
	check_word(281, 16'hA5A5);
	end_test("branch");
endtask

task automatic test_lea();
	int idx_a;
	int idx_b;
	begin_program();
	idx_a = prog.size();
	emit_spaced(encode9(4'b1110, 3'd3, 9'd5));
	emit_spaced(encode(4'b0111, 3'd3, 3'd6, 6'd0));
	idx_b = prog.size();
	emit_spaced(encode9(4'b1110, 3'd2, 9'h1FD));
	emit_spaced(encode(4'b0111, 3'd2, 3'd6, 6'd1));
	end_program();
	start_run();
	release_and_wait();
	check_word(256, 16'(idx_a * 2 + 2 + 10));
	check_word(257, 16'(idx_b * 2 + 2 - 6));
	end_test("lea");
endtask

initial begin
	reset = 1'b1;
	fixed_lat = 3'd0;
	test_reset();
	test_arith("arith", 1'b1);
	test_memory();
	test_branch();
	test_lea();
	fixed_lat = 3'd4;
	test_arith("arith_latency4", 1'b0);
	$display("tests passed %0d failed %0d", passes, fails);
	if (fails == 0)
		$display("sim passed");
	else
		$display("sim failed");
	$finish;
end

endmodule : tb_cpu

//--- src.f
source/lc3b_types.sv
source/alu.sv
source/regfile.sv
source/control_rom.sv
source/stall_unit.sv
source/datapath.sv
source/cpu.sv
dv/tb_line_memory.sv
dv/tb_cpu.sv

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f src.f -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -qx "sim passed" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
